// ==== include/cnn_consts.svh ====
/*
 * Convolution engine sizes
 * Picture, kernel, read lane and write word dimensions plus the
 * memory address width shared by the package and the RTL blocks.
 */
`ifndef CNN_CONSTS_SVH
`define CNN_CONSTS_SVH

// ==========================================================================
// Memory
// ==========================================================================
`define CNN_ADDR_W    19                 // Byte address width

// ==========================================================================
// Geometry
// ==========================================================================
`define CNN_PIC_ROWS  8                  // Picture rows
`define CNN_PIC_COLS  8                  // Picture columns, also the row pitch
`define CNN_KER_ROWS  4                  // Kernel lines per window
`define CNN_KER_COLS  4                  // Kernel bytes per line
`define CNN_LANES     4                  // Picture bytes per read
`define CNN_WR_BYTES  4                  // Result bytes per write word
`define CNN_WIN_LAST  (`CNN_PIC_ROWS - `CNN_KER_ROWS)  // Last window row/column

`endif

// ==== hdl/cnn_pkg.sv ====
/*
 * Convolution engine types
 * Vector typedefs for addresses, data lanes and counters, and the
 * state encoding of the sequencing FSM.
 */
`default_nettype none

`include "cnn_consts.svh"

package cnn_pkg;

  typedef logic        [`CNN_ADDR_W-1:0]        addr_t;       // Memory byte address
  typedef logic        [7:0]                    pix_t;        // Unsigned picture byte
  typedef logic signed [7:0]                    wgt_t;        // Signed weight byte
  typedef logic signed [31:0]                   acc_t;        // Window sum and bias
  typedef logic        [8*`CNN_LANES-1:0]       lane_data_t;  // One picture row read
  typedef logic        [8*`CNN_KER_ROWS*`CNN_KER_COLS-1:0] wgt_block_t;  // Whole kernel
  typedef logic        [8*`CNN_WR_BYTES-1:0]    wr_word_t;    // One write word
  typedef logic        [2:0]                    win_idx_t;    // Window row or column
  typedef logic        [1:0]                    line_idx_t;   // Kernel line
  typedef logic        [2:0]                    byte_cnt_t;   // Valid bytes in a write

  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    LOAD   = 3'd1,
    READ   = 3'd2,
    CALC   = 3'd3,
    FINISH = 3'd4,
    WRITE  = 3'd5
  } cnn_state_t;

endpackage

`default_nettype wire

// ==== hdl/cnn_fsm.sv ====
/*
 * Convolution engine sequencer
 * Walks the weight/bias load, the per-row picture reads and
 * accumulations, window completion and result writes, and issues
 * one-cycle strobes to the datapath blocks.
 */
`timescale 1ns/1ps
`default_nettype none

module cnn_fsm
  import cnn_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       go,
  input  logic       weights_ready,   // Kernel and bias both returned
  input  logic       pic_valid,
  input  logic       wr_ack,
  input  logic       window_end,      // Last kernel line of the window
  input  logic       run_end,         // Counters sit on the last window
  input  logic       word_full,       // This result completes the word
  output cnn_state_t state,
  output logic       start,
  output logic       load,
  output logic       calc,
  output logic       finish,
  output logic       write_done,
  output logic       busy,
  output logic       done
);

  cnn_state_t next_state;
  logic       last_win;               // Final window already finished

  // ==========================================================================
  // Next state
  // ==========================================================================
  always_comb
  begin
    next_state = state;
    case (state)
      IDLE:    if (go) next_state = LOAD;
      LOAD:    if (weights_ready) next_state = READ;
      READ:    if (pic_valid) next_state = CALC;
      CALC:    next_state = window_end ? FINISH : READ;
      FINISH:  next_state = (word_full || run_end) ? WRITE : READ;
      WRITE:
      begin
        if (wr_ack)
          next_state = last_win ? IDLE : READ;
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= next_state;
  end

  // Remember that the final partial or full word is the one in flight
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      last_win <= 1'b0;
    else if (start)
      last_win <= 1'b0;
    else if (state == FINISH && run_end)
      last_win <= 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      done <= 1'b0;
    else
      done <= write_done && last_win;     // One cycle after the final ack
  end

  // ==========================================================================
  // Strobes
  // ==========================================================================
  assign start      = (state == IDLE) && go;
  assign load       = (state == LOAD) && weights_ready;
  assign calc       = (state == CALC);
  assign finish     = (state == FINISH);
  assign write_done = (state == WRITE) && wr_ack;
  assign busy       = (state != IDLE);

  // The memory only acknowledges a write that was requested
  a_ack_in_write: assert property (@(posedge clk) disable iff (!rst_n)
    wr_ack |-> state == WRITE)
    else $error("wr_ack seen outside WRITE");

endmodule

`default_nettype wire

// ==== hdl/window_counter.sv ====
/*
 * Window position counters
 * Tracks the kernel line inside a window and the window column and
 * row inside the picture, and forms the address of the next picture
 * row read.
 */
`timescale 1ns/1ps
`default_nettype none

`include "cnn_consts.svh"

module window_counter
  import cnn_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  start,
  input  logic  calc,
  input  logic  finish,
  input  addr_t addr_x,
  output addr_t pic_addr,
  output logic  window_end,
  output logic  run_end
);

  line_idx_t line;                         // Kernel line being read
  win_idx_t  win_col;
  win_idx_t  win_row;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      line    <= '0;
      win_col <= '0;
      win_row <= '0;
    end
    else if (start)
    begin
      line    <= '0;
      win_col <= '0;
      win_row <= '0;
    end
    else if (calc)
      line <= line_idx_t'(line + 1'b1);    // Wraps to 0 after the last line
    else if (finish)
    begin
      if (win_col != win_idx_t'(`CNN_WIN_LAST))
        win_col <= win_idx_t'(win_col + 1'b1);
      else if (win_row != win_idx_t'(`CNN_WIN_LAST))
      begin
        win_col <= '0;                     // Next window row
        win_row <= win_idx_t'(win_row + 1'b1);
      end
    end
  end

  // Row start of (window row + line), then step right by the window column
  assign pic_addr = addr_x
                  + addr_t'((addr_t'(win_row) + addr_t'(line)) * `CNN_PIC_COLS)
                  + addr_t'(win_col);

  assign window_end = (line == line_idx_t'(`CNN_KER_ROWS - 1));
  assign run_end    = (win_row == win_idx_t'(`CNN_WIN_LAST))
                   && (win_col == win_idx_t'(`CNN_WIN_LAST));

  a_win_range: assert property (@(posedge clk) disable iff (!rst_n)
    finish |=> (win_row <= win_idx_t'(`CNN_WIN_LAST))
            && (win_col <= win_idx_t'(`CNN_WIN_LAST)))
    else $error("window index beyond the picture");

endmodule

`default_nettype wire

// ==== hdl/conv_accumulator.sv ====
/*
 * Window accumulator
 * Holds the kernel, the bias and the latest picture row, adds one
 * four-lane signed dot product per row and clamps the biased window
 * sum into an output byte.
 */
`timescale 1ns/1ps
`default_nettype none

`include "cnn_consts.svh"

module conv_accumulator
  import cnn_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       wgt_valid,
  input  logic       bias_valid,
  input  logic       pic_valid,
  input  logic       calc,
  input  logic       finish,
  input  wgt_block_t wgt_data,
  input  acc_t       bias_data,
  input  lane_data_t pic_data,
  output pix_t       result
);

  wgt_block_t kernel_q;                  // Byte k holds line k/4, column k%4
  acc_t       bias_q;
  lane_data_t lane_q;                    // Lane c is picture column col+c
  acc_t       acc_q;
  acc_t       dot;
  acc_t       sum;
  line_idx_t  line;                      // Kernel line of the next calc

  always_ff @(posedge clk)
  begin
    if (wgt_valid)
      kernel_q <= wgt_data;
    if (bias_valid)
      bias_q <= bias_data;
    if (pic_valid)
      lane_q <= pic_data;
    if (finish)
      result <= (sum < 0) ? 8'h00 : (sum > 32'sd255) ? 8'hFF : sum[7:0];
  end

  // Signed weight times zero-extended pixel, summed over the lanes
  always_comb
  begin
    dot = '0;
    for (int c = 0; c < `CNN_LANES; c++)
      dot = dot + $signed({1'b0, lane_q[8*c +: 8]})
                * wgt_t'(kernel_q[8*(line*`CNN_KER_COLS + c) +: 8]);
  end

  assign sum = acc_q + bias_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      acc_q <= '0;
      line  <= '0;
    end
    else if (calc)
    begin
      acc_q <= acc_q + dot;
      line  <= line_idx_t'(line + 1'b1);
    end
    else if (finish)
      acc_q <= '0;                       // Fresh sum for the next window
  end

endmodule

`default_nettype wire

// ==== hdl/result_packer.sv ====
/*
 * Result packer
 * Collects result bytes into a 32-bit write word, oldest byte in
 * the lowest lane, and keeps the write address and byte count.
 */
`timescale 1ns/1ps
`default_nettype none

`include "cnn_consts.svh"

module result_packer
  import cnn_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start,
  input  logic      write_done,
  input  logic      finish,
  input  pix_t      result,
  input  addr_t     addr_z,
  output addr_t     wr_addr,
  output wr_word_t  wr_data,
  output byte_cnt_t wr_size,
  output logic      word_full
);

  wr_word_t  word_q;
  byte_cnt_t fill;                         // Lanes already stored in word_q
  logic      pend;                         // Result register just updated
  wr_word_t  merged;

  assign merged = word_q | (wr_word_t'(result) << {fill, 3'b000});

  // The new byte shows up on the write port in the cycle it lands
  assign wr_data   = pend ? merged : word_q;
  assign wr_size   = byte_cnt_t'(fill + byte_cnt_t'(pend));
  assign word_full = (fill == byte_cnt_t'(`CNN_WR_BYTES - 1));

  always_ff @(posedge clk)
  begin
    if (start || write_done)
      word_q <= '0;
    else if (pend)
      word_q <= merged;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pend    <= 1'b0;
      fill    <= '0;
      wr_addr <= '0;
    end
    else
    begin
      pend <= finish;
      if (start)
      begin
        fill    <= '0;
        wr_addr <= addr_z;
      end
      else if (write_done)
      begin
        fill    <= '0;
        wr_addr <= wr_addr + addr_t'(wr_size);   // Next free byte
      end
      else if (pend)
        fill <= byte_cnt_t'(fill + 1'b1);
    end
  end

  a_size_range: assert property (@(posedge clk) disable iff (!rst_n)
    pend |-> wr_size <= byte_cnt_t'(`CNN_WR_BYTES))
    else $error("write word overfilled");

endmodule

`default_nettype wire

// ==== hdl/cnn_top.sv ====
/*
 * Convolution engine top level
 * Connects the sequencer, window counters, accumulator and result
 * packer to the software strobes and the four memory ports.
 */
`timescale 1ns/1ps
`default_nettype none

module cnn_top
  import cnn_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  // Software side
  input  logic       go,
  input  addr_t      addr_x,
  input  addr_t      addr_y,
  input  addr_t      addr_bias,
  input  addr_t      addr_z,
  output logic       busy,
  output logic       done,
  // Picture read
  output logic       pic_req,
  output addr_t      pic_addr,
  input  lane_data_t pic_data,
  input  logic       pic_valid,
  // Weight read
  output logic       wgt_req,
  output addr_t      wgt_addr,
  input  wgt_block_t wgt_data,
  input  logic       wgt_valid,
  // Bias read
  output logic       bias_req,
  output addr_t      bias_addr,
  input  acc_t       bias_data,
  input  logic       bias_valid,
  // Result write
  output logic       wr_req,
  output addr_t      wr_addr,
  output wr_word_t   wr_data,
  output byte_cnt_t  wr_size,
  input  logic       wr_ack
);

  cnn_state_t state;
  logic       start, load, calc, finish, write_done;
  logic       weights_ready, window_end, run_end, word_full;
  logic       wgt_got, bias_got;          // Read returned during this LOAD
  pix_t       result;

  // ==========================================================================
  // Load handshake tracking
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wgt_got  <= 1'b0;
      bias_got <= 1'b0;
    end
    else if (load || start)
    begin
      wgt_got  <= 1'b0;
      bias_got <= 1'b0;
    end
    else
    begin
      if (wgt_valid)
        wgt_got <= 1'b1;
      if (bias_valid)
        bias_got <= 1'b1;
    end
  end

  assign weights_ready = (wgt_got || wgt_valid) && (bias_got || bias_valid);

  assign wgt_req   = (state == LOAD) && !wgt_got;   // Drops after its valid
  assign bias_req  = (state == LOAD) && !bias_got;
  assign pic_req   = (state == READ);
  assign wr_req    = (state == WRITE);
  assign wgt_addr  = addr_y;
  assign bias_addr = addr_bias;

  cnn_fsm u_fsm (
    .clk(clk), .rst_n(rst_n), .go(go), .weights_ready(weights_ready),
    .pic_valid(pic_valid), .wr_ack(wr_ack), .window_end(window_end),
    .run_end(run_end), .word_full(word_full), .state(state), .start(start),
    .load(load), .calc(calc), .finish(finish), .write_done(write_done),
    .busy(busy), .done(done)
  );

  window_counter u_window_counter (
    .clk(clk), .rst_n(rst_n), .start(start), .calc(calc), .finish(finish),
    .addr_x(addr_x), .pic_addr(pic_addr), .window_end(window_end),
    .run_end(run_end)
  );

  conv_accumulator u_conv_accumulator (
    .clk(clk), .rst_n(rst_n), .wgt_valid(wgt_valid), .bias_valid(bias_valid),
    .pic_valid(pic_valid), .calc(calc), .finish(finish), .wgt_data(wgt_data),
    .bias_data(bias_data), .pic_data(pic_data), .result(result)
  );

  result_packer u_result_packer (
    .clk(clk), .rst_n(rst_n), .start(start), .write_done(write_done),
    .finish(finish), .result(result), .addr_z(addr_z), .wr_addr(wr_addr),
    .wr_data(wr_data), .wr_size(wr_size), .word_full(word_full)
  );

endmodule

`default_nettype wire

// ==== bench/mem_model.sv ====
/*
 * Behavioral memory for the convolution engine testbench
 * One byte array behind the picture, weight and bias read ports with
 * a random read latency, and a write port that acknowledges after a
 * random delay of 0 to 5 cycles.
 */
`timescale 1ns/1ps
`default_nettype none

`include "cnn_consts.svh"

module mem_model
  import cnn_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       pic_req,
  input  addr_t      pic_addr,
  output lane_data_t pic_data,
  output logic       pic_valid,
  input  logic       wgt_req,
  input  addr_t      wgt_addr,
  output wgt_block_t wgt_data,
  output logic       wgt_valid,
  input  logic       bias_req,
  input  addr_t      bias_addr,
  output acc_t       bias_data,
  output logic       bias_valid,
  input  logic       wr_req,
  input  addr_t      wr_addr,
  input  wr_word_t   wr_data,
  input  byte_cnt_t  wr_size,
  output logic       wr_ack
);

  logic [7:0] mem [0:4095];                  // Low 12 address bits decoded
  logic [2:0] pic_cnt, wgt_cnt, bias_cnt;    // Cycles to valid, 0 when idle
  logic [2:0] wr_cnt;
  logic       wr_wait;                       // Write delay already drawn

  initial
  begin
    for (int i = 0; i < 4096; i++)
      mem[i] <= 8'(i) ^ 8'(i >> 4) ^ 8'h5A;
  end

  function automatic logic [7:0] byte_at(addr_t a);
    return mem[a[11:0]];
  endfunction

  task automatic store(addr_t a, logic [7:0] v);
    mem[a[11:0]] <= v;
  endtask

  // Draw a latency of 1 to 4 on a new request, then count down
  function automatic logic [2:0] step(logic req, logic valid, logic [2:0] cnt);
    if (!req || valid)
      return cnt;
    if (cnt == 3'd0)
      return 3'(1 + $urandom % 4);
    return cnt - 3'd1;
  endfunction

  // ==========================================================================
  // Read ports
  // ==========================================================================
  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      {pic_cnt, wgt_cnt, bias_cnt}       <= '0;
      {pic_valid, wgt_valid, bias_valid} <= '0;
      pic_data                           <= '0;
      wgt_data                           <= '0;
      bias_data                          <= '0;
    end
    else
    begin
      pic_cnt    <= step(pic_req, pic_valid, pic_cnt);
      wgt_cnt    <= step(wgt_req, wgt_valid, wgt_cnt);
      bias_cnt   <= step(bias_req, bias_valid, bias_cnt);
      pic_valid  <= pic_req && !pic_valid && (pic_cnt == 3'd1);
      wgt_valid  <= wgt_req && !wgt_valid && (wgt_cnt == 3'd1);
      bias_valid <= bias_req && !bias_valid && (bias_cnt == 3'd1);
      for (int c = 0; c < `CNN_LANES; c++)
        pic_data[8*c +: 8] <= byte_at(pic_addr + addr_t'(c));
      for (int k = 0; k < `CNN_KER_ROWS * `CNN_KER_COLS; k++)
        wgt_data[8*k +: 8] <= byte_at(wgt_addr + addr_t'(k));
      for (int k = 0; k < 4; k++)
        bias_data[8*k +: 8] <= byte_at(bias_addr + addr_t'(k));  // Little endian
    end
  end

  // ==========================================================================
  // Write port
  // ==========================================================================
  always @(posedge clk or negedge rst_n)
  begin : write_port
    int unsigned wait_left;
    if (!rst_n)
    begin
      wr_ack  <= 1'b0;
      wr_wait <= 1'b0;
      wr_cnt  <= '0;
    end
    else
    begin
      wr_ack <= 1'b0;
      if (wr_req && !wr_ack)
      begin
        wait_left = wr_wait ? wr_cnt : $urandom % 6;
        if (wait_left == 0)
        begin
          wr_ack  <= 1'b1;
          wr_wait <= 1'b0;
          for (int b = 0; b < wr_size; b++)
            mem[12'(wr_addr + addr_t'(b))] <= wr_data[8*b +: 8];
        end
        else
        begin
          wr_wait <= 1'b1;
          wr_cnt  <= 3'(wait_left - 1);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== bench/tb_cnn.sv ====
/*
 * Convolution engine testbench
 * Runs a table of five cases through the engine against a behavioral
 * memory and checks every result byte, the read and write traffic
 * and the busy and done timing against a reference model.
 */
`timescale 1ns/1ps
`default_nettype none

`include "cnn_consts.svh"

module tb_cnn
  import cnn_pkg::*;
();

  localparam int NUM_CASES  = 5;
  localparam int WIN_SIDE   = `CNN_WIN_LAST + 1;
  localparam int NUM_OUT    = WIN_SIDE * WIN_SIDE;                  // 25 result bytes
  localparam int NUM_WRITES = (NUM_OUT + `CNN_WR_BYTES - 1) / `CNN_WR_BYTES;
  // Worst run: 100 row reads of up to 7 cycles, 25 finishes, 7 slow writes
  localparam int RUN_CYCLES = 1000;
  localparam int MAX_CYCLES = NUM_CASES * RUN_CYCLES + 100;

  typedef enum logic [2:0] {W_ONES, W_ALT, W_RAND, W_POS, W_NEG} wkind_t;

  typedef struct packed {
    addr_t       pic_at;
    addr_t       wgt_at;
    addr_t       bias_at;
    addr_t       out_at;
    logic [31:0] bias;
    wkind_t      kind;
  } case_t;

  logic       clk, rst_n, go, busy, done;
  addr_t      addr_x, addr_y, addr_bias, addr_z;
  logic       pic_req, pic_valid, wgt_req, wgt_valid, bias_req, bias_valid;
  addr_t      pic_addr, wgt_addr, bias_addr, wr_addr;
  lane_data_t pic_data;
  wgt_block_t wgt_data;
  acc_t       bias_data;
  logic       wr_req, wr_ack;
  wr_word_t   wr_data;
  byte_cnt_t  wr_size;

  case_t       cases [NUM_CASES];
  int          pix [64];                     // Reference copy of the picture
  int          wts [16];                     // Signed weights, line major
  int          bias_v;
  int          cycles = 0;
  int          wgt_reqs, bias_reqs;
  int unsigned seed = 35;
  addr_t       seen_addr [$];
  byte_cnt_t   seen_size [$];
  logic        wgt_req_q = 1'b0, bias_req_q = 1'b0, wr_req_q = 1'b0, wr_ack_q = 1'b0;
  addr_t       wr_addr_q;
  wr_word_t    wr_data_q;
  byte_cnt_t   wr_size_q;

  cnn_top   u_dut (.*);
  mem_model u_mem (.*);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic compare(string what, logic [31:0] got, logic [31:0] exp);
    if (got !== exp)
    begin
      $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  function automatic case_t entry(addr_t p, addr_t w, addr_t b, addr_t o, int bias,
                                  wkind_t kind);
    case_t e;
    e.pic_at  = p;
    e.wgt_at  = w;
    e.bias_at = b;
    e.out_at  = o;
    e.bias    = bias;
    e.kind    = kind;
    return e;
  endfunction

  function automatic int weight_for(wkind_t kind, int k);
    case (kind)
      W_ONES:  return 1;
      W_ALT:   return ((k / `CNN_KER_COLS + k % `CNN_KER_COLS) % 2) ? -1 : 1;  // Checkerboard
      W_RAND:  return int'($urandom % 256) - 128;
      W_POS:   return 127;
      default: return -128;
    endcase
  endfunction

  // Window sum plus bias, clamped to a byte
  function automatic int expected_byte(int wr, int wc);
    int sum;
    sum = bias_v;
    for (int l = 0; l < `CNN_KER_ROWS; l++)
      for (int c = 0; c < `CNN_KER_COLS; c++)
        sum += wts[l*`CNN_KER_COLS + c] * pix[(wr + l)*`CNN_PIC_COLS + wc + c];
    if (sum < 0)
      return 0;
    if (sum > 255)
      return 255;
    return sum;
  endfunction

  task automatic load_memory(case_t tc);
    bias_v = tc.bias;
    for (int k = 0; k < 16; k++)
    begin
      wts[k] = weight_for(tc.kind, k);
      u_mem.store(tc.wgt_at + addr_t'(k), 8'(wts[k]));
    end
    for (int k = 0; k < 4; k++)
      u_mem.store(tc.bias_at + addr_t'(k), 8'(tc.bias >> (8*k)));
    for (int k = 0; k < 64; k++)
    begin
      pix[k] = $urandom % 256;
      u_mem.store(tc.pic_at + addr_t'(k), 8'(pix[k]));
    end
  endtask

  // ==========================================================================
  // One run: start, wait for done, check traffic and results
  // ==========================================================================
  task automatic run_case(int t, case_t tc);
    int left;
    load_memory(tc);
    wgt_reqs  = 0;
    bias_reqs = 0;
    seen_addr.delete();
    seen_size.delete();
    @(posedge clk);
    addr_x    <= tc.pic_at;
    addr_y    <= tc.wgt_at;
    addr_bias <= tc.bias_at;
    addr_z    <= tc.out_at;
    go        <= 1'b1;
    @(negedge clk);
    compare("busy before go is sampled", busy, 1'b0);
    @(posedge clk);
    go <= 1'b0;
    @(negedge clk);
    while (!done)
    begin
      compare($sformatf("case %0d busy during run", t), busy, 1'b1);
      @(negedge clk);
    end
    compare("busy with done", busy, 1'b0);
    @(negedge clk);
    compare("idle strobes after done", {pic_req, wgt_req, bias_req, wr_req, busy, done}, '0);
    compare("weight reads", wgt_reqs, 1);
    compare("bias reads", bias_reqs, 1);
    compare("write count", seen_addr.size(), NUM_WRITES);
    left = NUM_OUT;
    for (int i = 0; i < NUM_WRITES; i++)
    begin
      compare("write address", seen_addr[i], tc.out_at + addr_t'(i * `CNN_WR_BYTES));
      compare("write size", seen_size[i], (left < `CNN_WR_BYTES) ? left : `CNN_WR_BYTES);
      left -= `CNN_WR_BYTES;
    end
    for (int wr = 0; wr < WIN_SIDE; wr++)
      for (int wc = 0; wc < WIN_SIDE; wc++)
        compare($sformatf("case %0d result %0d", t, wr*WIN_SIDE + wc),
                u_mem.byte_at(tc.out_at + addr_t'(wr*WIN_SIDE + wc)), expected_byte(wr, wc));
  endtask

  // Bus monitor, sampled away from the driving edge
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (wgt_req && !wgt_req_q)
      begin
        wgt_reqs++;
        compare("weight read address", wgt_addr, addr_y);
      end
      if (bias_req && !bias_req_q)
      begin
        bias_reqs++;
        compare("bias read address", bias_addr, addr_bias);
      end
      if (wr_req && wr_req_q && !wr_ack_q)
      begin
        compare("wr_addr held", wr_addr, wr_addr_q);
        compare("wr_data held", wr_data, wr_data_q);
        compare("wr_size held", wr_size, wr_size_q);
      end
      if (wr_ack_q)
        compare("wr_req after ack", wr_req, 1'b0);
      if (wr_req && wr_ack)
      begin
        seen_addr.push_back(wr_addr);
        seen_size.push_back(wr_size);
      end
    end
    wgt_req_q  <= wgt_req;
    bias_req_q <= bias_req;
    wr_req_q   <= wr_req;
    wr_ack_q   <= wr_ack;
    wr_addr_q  <= wr_addr;
    wr_data_q  <= wr_data;
    wr_size_q  <= wr_size;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout: the engine did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors found");
      $fatal(1);
    end
  end

  initial
  begin
    void'($urandom(seed));
    rst_n     = 1'b0;
    go        = 1'b0;
    addr_x    = '0;
    addr_y    = '0;
    addr_bias = '0;
    addr_z    = '0;
    cases[0] = entry(19'h100, 19'h200, 19'h210, 19'h300, 0, W_ONES);
    cases[1] = entry(19'h400, 19'h480, 19'h4C0, 19'h500, 20, W_ALT);
    cases[2] = entry(19'h601, 19'h655, 19'h66A, 19'h703, 37, W_RAND);   // Unaligned
    cases[3] = entry(19'h800, 19'h850, 19'h860, 19'h900, -5000, W_POS);
    cases[4] = entry(19'hA00, 19'hA50, 19'hA60, 19'hB00, 1000, W_NEG);
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    compare("strobes after reset", {pic_req, wgt_req, bias_req, wr_req, busy, done}, '0);
    for (int t = 0; t < NUM_CASES; t++)
      run_case(t, cases[t]);
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
hdl/cnn_pkg.sv
hdl/cnn_fsm.sv
hdl/window_counter.sv
hdl/conv_accumulator.sv
hdl/result_packer.sv
hdl/cnn_top.sv
bench/mem_model.sv
bench/tb_cnn.sv
